// File: hub75_geom_pkg.sv
`default_nettype none

package hub75_geom_pkg;

  // ####################################################################
  // panel geometry.
  // ####################################################################
  localparam int COLS = 64;      // columns in one scan row.
  localparam int SCAN_ROWS = 32; // 1/32 scan, two pixels per column.
  localparam int COL_W = 6;
  localparam int ROW_W = 5;

  // ####################################################################
  // bit planes and timing.
  // ####################################################################
  localparam int PLANES = 4;
  localparam int PLANE_W = 2;

  // plane p is enabled for BCM_BASE << p cycles.
  localparam int BCM_BASE = 160;
  localparam int BCM_W = 11; // holds BCM_BASE << (PLANES - 1).

  // one plane shift takes two cycles per column plus two of startup.
  localparam int SHIFT_CYCLES = 2 * COLS + 2;
  localparam int STEP_W = COL_W + 2;

endpackage

`default_nettype wire

// File: hub75_pixel_pkg.sv
`default_nettype none

package hub75_pixel_pkg;

  localparam int DEPTH = 4;    // bits per colour channel.
  localparam int CHANNELS = 6; // r1, g1, b1, r2, g2, b2.
  localparam int PAIR_W = CHANNELS * DEPTH;

  // One column word. The writer sees two pixels, the shifter sees six
  // channels so that one bit plane can be picked out of all of them.
  typedef union packed {
    struct packed {
      logic [DEPTH-1:0] top_r;
      logic [DEPTH-1:0] top_g;
      logic [DEPTH-1:0] top_b;
      logic [DEPTH-1:0] bot_r;
      logic [DEPTH-1:0] bot_g;
      logic [DEPTH-1:0] bot_b;
    } pix;
    logic [0:CHANNELS-1][DEPTH-1:0] chan; // chan[0] is r1, chan[5] is b2.
  } pixel_pair_u;

endpackage

`default_nettype wire

// File: row_cache.sv
`timescale 1ns/1ns
`default_nettype none

module row_cache
  import hub75_geom_pkg::*;
  import hub75_pixel_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              load_start,
  input  logic [PAIR_W-1:0] pix_data,
  input  logic              pix_valid,
  output logic              pix_ready,
  output logic              load_done,
  input  logic [COL_W-1:0]  rd_col,
  output pixel_pair_u       rd_data
);

  pixel_pair_u      mem [COLS];
  logic [COL_W-1:0] wr_col;
  logic             take;

  assign take = pix_valid && pix_ready;

  // ####################################################################
  // write side. one row per load_start, in column order.
  // ####################################################################
  always_ff @(posedge clk) begin
    if (rst) begin
      pix_ready <= 1'b0;
      load_done <= 1'b0;
      wr_col    <= '0;
    end else begin
      load_done <= 1'b0;
      if (load_start) begin
        pix_ready <= 1'b1;
        wr_col    <= '0;
      end else if (take) begin
        wr_col <= wr_col + 1'b1;
        if (wr_col == COL_W'(COLS - 1)) begin // last column of the row.
          pix_ready <= 1'b0;
          load_done <= 1'b1;
        end
      end
    end
  end

  // storage and the shifter's read port.
  always_ff @(posedge clk) begin
    if (take) begin
      mem[wr_col] <= pix_data;
    end
    rd_data <= mem[rd_col]; // data follows rd_col by one cycle.
  end

endmodule

`default_nettype wire

// File: plane_shifter.sv
`timescale 1ns/1ns
`default_nettype none

module plane_shifter
  import hub75_geom_pkg::*;
  import hub75_pixel_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  logic               shift_start,
  input  logic [PLANE_W-1:0] plane_sel,
  output logic [COL_W-1:0]   rd_col,
  input  pixel_pair_u        rd_data,
  output logic               r1,
  output logic               g1,
  output logic               b1,
  output logic               r2,
  output logic               g2,
  output logic               b2,
  output logic               hub_clk,
  output logic               shift_done
);

  logic               busy;
  logic [STEP_W-1:0]  step;
  logic [PLANE_W-1:0] plane;
  logic               last_step;

  // Two steps per column. Column c is read on step 2c, sits on the pins
  // with hub_clk low on step 2c+2 and is clocked in on step 2c+3.
  assign rd_col    = step[COL_W:1];
  assign last_step = (step == STEP_W'(SHIFT_CYCLES - 1));

  // ####################################################################
  // step counter and panel clock.
  // ####################################################################
  always_ff @(posedge clk) begin
    if (rst) begin
      busy       <= 1'b0;
      step       <= '0;
      plane      <= '0;
      hub_clk    <= 1'b0;
      shift_done <= 1'b0;
    end else begin
      shift_done <= 1'b0;
      if (shift_start) begin
        busy  <= 1'b1;
        step  <= '0;
        plane <= plane_sel;
      end else if (busy) begin
        step <= step + 1'b1;
        if (step[0]) begin
          hub_clk <= 1'b0; // new data goes out with the falling edge.
        end else if (step != '0) begin
          hub_clk <= 1'b1;
        end
        if (step == STEP_W'(SHIFT_CYCLES - 2)) begin
          shift_done <= 1'b1; // lines up with the last hub_clk high.
        end
        if (last_step) begin
          busy <= 1'b0;
        end
      end
    end
  end

  // ####################################################################
  // colour pins. bit plane of every channel at once.
  // ####################################################################
  always_ff @(posedge clk) begin
    if (busy && step[0] && !last_step) begin
      r1 <= rd_data.chan[0][plane];
      g1 <= rd_data.chan[1][plane];
      b1 <= rd_data.chan[2][plane];
      r2 <= rd_data.chan[3][plane];
      g2 <= rd_data.chan[4][plane];
      b2 <= rd_data.chan[5][plane];
    end
  end

endmodule

`default_nettype wire

// File: bcm_timer.sv
`timescale 1ns/1ns
`default_nettype none

module bcm_timer
  import hub75_geom_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  logic               bcm_start,
  input  logic [PLANE_W-1:0] plane_sel,
  output logic               oe_n,
  output logic               bcm_done
);

  logic [BCM_W-1:0] count;

  // oe_n low doubles as the busy flag of the timer.
  always_ff @(posedge clk) begin
    if (rst) begin
      oe_n     <= 1'b1;
      bcm_done <= 1'b0;
      count    <= '0;
    end else begin
      bcm_done <= 1'b0;
      if (bcm_start) begin
        oe_n  <= 1'b0;
        count <= BCM_W'((BCM_BASE << plane_sel) - 1); // weight of the plane.
      end else if (!oe_n) begin
        if (count == '0) begin
          oe_n     <= 1'b1;
          bcm_done <= 1'b1; // same cycle the panel goes dark.
        end else begin
          count <= count - 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: screen_control.sv
`timescale 1ns/1ns
`default_nettype none

module screen_control
  import hub75_geom_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  output logic               load_start,
  input  logic               load_done,
  output logic               shift_start,
  input  logic               shift_done,
  output logic               bcm_start,
  input  logic               bcm_done,
  output logic [PLANE_W-1:0] plane_sel,
  output logic               lat,
  output logic [ROW_W-1:0]   row_addr
);

  // One-hot sequencer. st_load kicks off the very first row, st_blank is
  // the dark cycle ahead of the latch, then lat and bcm_start themselves
  // mark the latch and display launch states. With none of them set the
  // machine waits for the pending stages.
  logic st_load;
  logic st_blank;

  logic load_pend;  // row load running.
  logic shift_pend; // plane shift running.
  logic disp_pend;  // plane display running.

  logic [ROW_W-1:0]   row_cnt;     // row held in the cache.
  logic [PLANE_W-1:0] shift_plane; // plane in the shifter or panel shift register.
  logic [PLANE_W-1:0] disp_plane;  // plane in the panel output latches.

  always_ff @(posedge clk) begin
    if (rst) begin
      st_load     <= 1'b1;
      st_blank    <= 1'b0;
      load_start  <= 1'b0;
      shift_start <= 1'b0;
      bcm_start   <= 1'b0;
      lat         <= 1'b0;
      load_pend   <= 1'b0;
      shift_pend  <= 1'b0;
      disp_pend   <= 1'b0;
      row_cnt     <= '0;
      row_addr    <= '0;
      shift_plane <= '0;
      disp_plane  <= '0;
      plane_sel   <= '0;
    end else begin
      st_load     <= 1'b0;
      st_blank    <= 1'b0;
      load_start  <= 1'b0;
      shift_start <= 1'b0;
      bcm_start   <= 1'b0;
      lat         <= 1'b0;

      if (shift_done) shift_pend <= 1'b0;
      if (bcm_done) disp_pend <= 1'b0;

      // ################################################################
      // sequence.
      // ################################################################
      if (st_load) begin
        load_start <= 1'b1;
        load_pend  <= 1'b1;
      end else if (load_done) begin
        // fresh row in the cache, shift its first plane.
        load_pend   <= 1'b0;
        shift_start <= 1'b1;
        shift_pend  <= 1'b1;
        shift_plane <= '0;
        plane_sel   <= '0;
      end else if (st_blank) begin
        lat        <= 1'b1;
        disp_plane <= shift_plane;
        if (shift_plane == '0) begin
          row_addr <= row_cnt; // row select moves with the plane 0 latch.
        end
      end else if (lat) begin
        bcm_start <= 1'b1;
        disp_pend <= 1'b1;
        plane_sel <= disp_plane;
      end else if (bcm_start) begin
        // plane_sel belongs to the timer this cycle, so the next stage
        // is started one cycle after the display.
        if (disp_plane == PLANE_W'(PLANES - 1)) begin
          load_start <= 1'b1;
          load_pend  <= 1'b1;
          if (row_cnt == ROW_W'(SCAN_ROWS - 1)) begin
            row_cnt <= '0;
          end else begin
            row_cnt <= row_cnt + 1'b1;
          end
        end else begin
          shift_start <= 1'b1;
          shift_pend  <= 1'b1;
          shift_plane <= disp_plane + 1'b1;
          plane_sel   <= disp_plane + 1'b1;
        end
      end else if (!load_pend && !shift_pend && !disp_pend) begin
        st_blank <= 1'b1; // shift finished and panel dark.
      end
    end
  end

endmodule

`default_nettype wire

// File: hub75_top.sv
`timescale 1ns/1ns
`default_nettype none

module hub75_top
  import hub75_geom_pkg::*;
  import hub75_pixel_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic [PAIR_W-1:0] pix_data,
  input  logic              pix_valid,
  output logic              pix_ready,
  output logic              r1,
  output logic              g1,
  output logic              b1,
  output logic              r2,
  output logic              g2,
  output logic              b2,
  output logic              hub_clk,
  output logic              lat,
  output logic              oe_n,
  output logic [ROW_W-1:0]  row_addr
);

  logic               load_start;
  logic               load_done;
  logic               shift_start;
  logic               shift_done;
  logic               bcm_start;
  logic               bcm_done;
  logic [PLANE_W-1:0] plane_sel;
  logic [COL_W-1:0]   rd_col;
  pixel_pair_u        rd_data;

  row_cache u_row_cache (
    .clk        (clk),
    .rst        (rst),
    .load_start (load_start),
    .pix_data   (pix_data),
    .pix_valid  (pix_valid),
    .pix_ready  (pix_ready),
    .load_done  (load_done),
    .rd_col     (rd_col),
    .rd_data    (rd_data)
  );

  plane_shifter u_plane_shifter (
    .clk         (clk),
    .rst         (rst),
    .shift_start (shift_start),
    .plane_sel   (plane_sel),
    .rd_col      (rd_col),
    .rd_data     (rd_data),
    .r1          (r1),
    .g1          (g1),
    .b1          (b1),
    .r2          (r2),
    .g2          (g2),
    .b2          (b2),
    .hub_clk     (hub_clk),
    .shift_done  (shift_done)
  );

  bcm_timer u_bcm_timer (
    .clk       (clk),
    .rst       (rst),
    .bcm_start (bcm_start),
    .plane_sel (plane_sel),
    .oe_n      (oe_n),
    .bcm_done  (bcm_done)
  );

  screen_control u_screen_control (
    .clk         (clk),
    .rst         (rst),
    .load_start  (load_start),
    .load_done   (load_done),
    .shift_start (shift_start),
    .shift_done  (shift_done),
    .bcm_start   (bcm_start),
    .bcm_done    (bcm_done),
    .plane_sel   (plane_sel),
    .lat         (lat),
    .row_addr    (row_addr)
  );

endmodule

`default_nettype wire

// File: hub75_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module hub75_asserts
  import hub75_geom_pkg::*;
(
  input logic             clk,
  input logic             rst,
  input logic             lat,
  input logic             hub_clk,
  input logic             oe_n,
  input logic [ROW_W-1:0] row_addr
);

  // the panel latches its shift register while hub_clk rests low.
  lat_clk_apart: assert property (@(posedge clk) disable iff (rst) !(lat && hub_clk))
    else $error("lat and hub_clk are high together");

  dark_at_lat: assert property (@(posedge clk) disable iff (rst) lat |-> (oe_n && $past(oe_n)))
    else $error("oe_n is low around lat");

  row_moves_dark: assert property (@(posedge clk) disable iff (rst) !$stable(row_addr) |-> oe_n)
    else $error("row_addr changed while the panel was lit");

endmodule

bind hub75_top hub75_asserts u_asserts (
  .clk      (clk),
  .rst      (rst),
  .lat      (lat),
  .hub_clk  (hub_clk),
  .oe_n     (oe_n),
  .row_addr (row_addr)
);

`default_nettype wire

// File: tb_hub75.sv
`timescale 1ns/1ns
`default_nettype none

module tb_hub75
  import hub75_geom_pkg::*;
  import hub75_pixel_pkg::*;
();

  localparam int FRAME_WORDS = SCAN_ROWS * COLS;
  localparam int TOTAL_LATS = 2 * SCAN_ROWS * PLANES; // two full frames.
  localparam int FRAME_CYCLES = SCAN_ROWS * (COLS + PLANES * SHIFT_CYCLES + 15 * BCM_BASE + 40);
  localparam int DRIVE_DELAY = 2;

  logic clk = 1'b0;
  logic rst;
  logic [PAIR_W-1:0] pix_data;
  logic pix_valid, pix_ready;
  logic r1, g1, b1, r2, g2, b2;
  logic hub_clk, lat, oe_n;
  logic [ROW_W-1:0] row_addr;

  pixel_pair_u frame [FRAME_WORDS];
  logic [31:0] lcg_state;
  logic [ROW_W+COL_W-1:0] src_addr; // wraps at the end of the frame.
  int handshakes;

  logic [5:0] panel_sr [COLS];
  logic prev_hub_clk;
  logic [ROW_W-1:0] exp_row;
  logic [PLANE_W-1:0] exp_plane;
  int rise_count, rows_done, run_len, low_run, runs_checked;

  hub75_top uut (.*);

  always #10 clk = ~clk;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // bit p of the six channels in pin order r1, g1, b1, r2, g2, b2.
  function automatic logic [5:0] plane_bits(pixel_pair_u w, logic [PLANE_W-1:0] p);
    return {w.pix.top_r[p], w.pix.top_g[p], w.pix.top_b[p],
            w.pix.bot_r[p], w.pix.bot_g[p], w.pix.bot_b[p]};
  endfunction

  task automatic report_mismatch(string name, int expected, int actual);
    $display("CHECK FAILED at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_latch();
    logic [COL_W-1:0] col;
    logic [5:0] want;
    assert (rise_count == COLS) else report_mismatch("hub_clk edges per lat", COLS, rise_count);
    assert (row_addr == exp_row) else report_mismatch("row_addr", int'(exp_row), int'(row_addr));
    if (exp_plane == '0) begin // the whole row has been taken by now.
      assert (handshakes == (rows_done + 1) * COLS)
        else report_mismatch("pixel handshakes", (rows_done + 1) * COLS, handshakes);
    end
    col = '0;
    repeat (COLS) begin
      want = plane_bits(frame[{exp_row, col}], exp_plane);
      assert (panel_sr[col] == want)
        else report_mismatch($sformatf("colour pins, column %0d plane %0d", col, exp_plane),
                             int'(want), int'(panel_sr[col]));
      col = col + 1'b1;
    end
    run_len    = BCM_BASE << exp_plane;
    rise_count = 0;
    if (exp_plane == PLANE_W'(PLANES - 1)) begin
      rows_done = rows_done + 1;
      exp_row   = exp_row + 1'b1;
    end
    exp_plane = exp_plane + 1'b1;
  endtask

  // ####################################################################
  // pixel source with random gaps in pix_valid.
  // ####################################################################
  initial begin : pixel_source
    logic [31:0] rnd;
    logic took;
    pix_valid  = 1'b0;
    pix_data   = '0;
    lcg_state  = 32'd8884;
    src_addr   = '0;
    handshakes = 0;
    repeat (FRAME_WORDS) begin
      rnd = lcg_next();
      frame[src_addr] = rnd[31:8];
      src_addr = src_addr + 1'b1;
    end
    forever begin
      @(negedge clk);
      took = pix_valid && pix_ready;
      @(posedge clk);
      #DRIVE_DELAY;
      if (took) begin
        src_addr   = src_addr + 1'b1;
        handshakes = handshakes + 1;
      end
      rnd = lcg_next();
      pix_valid = (rnd[31:30] != 2'b00); // high three times in four.
      pix_data  = frame[src_addr];
    end
  end

  // ####################################################################
  // panel model. pins are sampled at the falling clk edge.
  // ####################################################################
  always @(negedge clk) begin : panel_model
    logic [COL_W-1:0] col;
    if (rst) begin
      prev_hub_clk = 1'b0;
      exp_row      = '0;
      exp_plane    = '0;
      rise_count   = 0;
      rows_done    = 0;
      run_len      = 0;
      low_run      = 0;
      runs_checked = 0;
    end else begin
      if (hub_clk && !prev_hub_clk) begin
        col = '0;
        repeat (COLS - 1) begin
          panel_sr[col] = panel_sr[col + 1'b1];
          col = col + 1'b1;
        end
        panel_sr[col] = {r1, g1, b1, r2, g2, b2}; // column 0 ends up in entry 0.
        rise_count = rise_count + 1;
      end
      prev_hub_clk = hub_clk;
      if (lat) begin
        check_latch();
      end
      if (!oe_n) begin
        low_run = low_run + 1;
      end else if (low_run != 0) begin
        assert (low_run == run_len) else report_mismatch("oe_n low cycles", run_len, low_run);
        runs_checked = runs_checked + 1;
        low_run = 0;
      end
    end
  end

  initial begin : watchdog
    repeat (2 * FRAME_CYCLES + 1000) @(posedge clk);
    $display("ERROR at %0t ns: two frames were not displayed in time", $time);
    $display("SIMULATION FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin : main_sequence
    rst = 1'b1;
    repeat (2) @(posedge clk);
    #DRIVE_DELAY;
    rst = 1'b0;
    repeat (2) begin // idle outputs until the first row arrives.
      @(negedge clk);
      assert (oe_n == 1'b1) else report_mismatch("oe_n", 1, int'(oe_n));
      assert (lat == 1'b0) else report_mismatch("lat", 0, int'(lat));
      assert (hub_clk == 1'b0) else report_mismatch("hub_clk", 0, int'(hub_clk));
      assert (pix_ready == 1'b0) else report_mismatch("pix_ready", 0, int'(pix_ready));
    end
    wait (runs_checked == TOTAL_LATS);
    @(negedge clk);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
hub75_geom_pkg.sv
hub75_pixel_pkg.sv
row_cache.sv
plane_shifter.sv
bcm_timer.sv
screen_control.sv
hub75_top.sv
hub75_asserts.sv
tb_hub75.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_hub75
FILELIST  = list.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir
